//--- neoB1.f
b1Pkg.sv
lineBuffer.sv
spriteLineStage.sv
fixLatchStage.sv
palAddrStage.sv
watchdog.sv
neoB1.sv
neoB1Assertions.sv
tbClock.sv
neoB1Tb.sv

//--- neoB1Tb.sv
`timescale 1ns/1ps

module neoB1Tb;

	localparam int sweepLen = b1Pkg::lbDepth;	// One full line
	localparam int spriteCount = 32;
	localparam int fixLen = 64;	// Fix phase and priority phase length
	localparam int frameLen = 8;
	localparam int kickFrames = 5;
	localparam int wdFrames = 4;
	localparam int wdHold = 16;
	localparam int testCycles = 2 + 4 * sweepLen + spriteCount + 2 * fixLen
		+ (kickFrames + wdFrames) * frameLen + wdHold + 8;
	localparam int maxCycles = testCycles + 100;	// Margin for the drain

	typedef struct packed {
		b1Pkg::palAddrT addr;
		b1Pkg::paSrcE src;
	} expT;	// Expected palette bus

	logic S1H1;
	logic nS1H1;
	b1Pkg::cpuBusT cpuBus;
	b1Pkg::spriteWrT spriteWr;
	b1Pkg::fixInT fixIn;
	logic [7:0] pixelX;
	logic lineFlip;
	logic hBlank;
	logic frameStart;
	b1Pkg::palAddrT palAddr;
	b1Pkg::paSrcE paSrc;
	logic systemReset;

	logic [31:0] lfsrState = 32'h8bf8_a1a8;
	b1Pkg::lbEntryT shadowA [b1Pkg::lbDepth];	// Model of bank A
	b1Pkg::lbEntryT shadowB [b1Pkg::lbDepth];
	logic [7:0] heldData;	// Model of the fix latch
	logic [3:0] heldPal;
	expT expD1;
	expT expD2;	// Due on the outputs now
	logic validD1 = 1'b0;
	logic validD2 = 1'b0;
	int valueErrors = 0;
	int otherErrors = 0;
	int cycleCount = 0;
	int holdCycles;

	// Model scratch
	b1Pkg::lbEntryT scanEntry;
	b1Pkg::fixPixT fixCur;
	logic [7:0] curData;
	logic [3:0] curPal;
	logic cpuPal;

	tbClock uClock (
		.S1H1(S1H1),
		.nS1H1(nS1H1)
	);

	neoB1 #(
		.wdFrames(wdFrames),
		.wdHold(wdHold)
	) DUT (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.cpuBus(cpuBus),
		.spriteWr(spriteWr),
		.fixIn(fixIn),
		.pixelX(pixelX),
		.lineFlip(lineFlip),
		.hBlank(hBlank),
		.frameStart(frameStart),
		.palAddr(palAddr),
		.paSrc(paSrc),
		.systemReset(systemReset)
	);

	// Galois LFSR, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Priority rule: CPU, blank, opaque fix, sprite
	function automatic expT refPalAddr(input logic cpuHit, input logic [11:0] cpuAddr,
		input logic blank, input b1Pkg::fixPixT fp, input b1Pkg::lbEntryT spr);
		expT r;
		if (cpuHit)
		begin
			r.addr = cpuAddr;
			r.src = b1Pkg::srcCpu;
		end
		else if (blank)
		begin
			r.addr = '0;
			r.src = b1Pkg::srcBlank;
		end
		else if (fp.pix != 4'd0)
		begin
			r.addr = {4'd0, fp.pal, fp.pix};
			r.src = b1Pkg::srcFix;
		end
		else
		begin
			r.addr = {spr.pal, spr.color};
			r.src = b1Pkg::srcSprite;
		end
		return r;
	endfunction

	task automatic setIdle();
		cpuBus = '0;
		spriteWr = '0;
		fixIn = '0;
		pixelX = '0;
		hBlank = 1'b0;
		frameStart = 1'b0;
	endtask

	task automatic nextCycle();
		@(negedge S1H1);
	endtask

	task automatic checkResetLow();
		assert (systemReset === 1'b0)
		else
		begin
			valueErrors++;
			$display("Fail at %0t: systemReset high without watchdog expiry", $time);
		end
	endtask

	task automatic finishRun();
		int total;
		total = valueErrors + otherErrors + DUT.uAssert.assertFails;
		$display("Errors: %0d value, %0d other, %0d assertion", valueErrors, otherErrors,
			DUT.uAssert.assertFails);
		if (total == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	endtask

	initial
	begin
		for (int a = 0; a < b1Pkg::lbDepth; a++)
		begin
			shadowA[a] = '0;
			shadowB[a] = '0;
		end
	end

	// Reference pipeline, inputs sampled on the rising edge
	always @(posedge S1H1)
	begin
		if (nS1H1)
		begin
			validD1 <= 1'b0;
			validD2 <= 1'b0;
			heldData = '0;
			heldPal = '0;
		end
		else
		begin
			scanEntry = lineFlip ? shadowB[pixelX] : shadowA[pixelX];	// Read before clear
			curData = fixIn.load ? fixIn.data : heldData;
			curPal = fixIn.load ? fixIn.pal : heldPal;
			fixCur.pal = curPal;
			fixCur.pix = pixelX[0] ? curData[7:4] : curData[3:0];
			cpuPal = cpuBus.strobe && !cpuBus.addr[23] && cpuBus.addr[22];
			expD1 <= refPalAddr(cpuPal, cpuBus.addr[12:1], hBlank, fixCur, scanEntry);
			validD1 <= 1'b1;
			expD2 <= expD1;
			validD2 <= validD1;
			if (lineFlip)
			begin
				if (spriteWr.we)
					shadowA[spriteWr.x] = spriteWr.entry;
				shadowB[pixelX] = '0;
			end
			else
			begin
				if (spriteWr.we)
					shadowB[spriteWr.x] = spriteWr.entry;
				shadowA[pixelX] = '0;
			end
			if (fixIn.load)
			begin
				heldData = fixIn.data;
				heldPal = fixIn.pal;
			end
		end
	end

	// Compare where the outputs are settled
	always @(negedge S1H1)
	begin
		if (validD2 && !nS1H1)
			assert (palAddr === expD2.addr && paSrc === expD2.src)
			else
			begin
				valueErrors++;
				$display("Fail at %0t: palAddr %h src %s, expected %h src %s", $time, palAddr,
					paSrc.name(), expD2.addr, expD2.src.name());
			end
	end

	always @(posedge S1H1)
	begin
		cycleCount++;
		if (cycleCount >= maxCycles)
		begin
			otherErrors++;
			$display("Timeout: test sequence did not finish within %0d cycles", maxCycles);
			finishRun();
		end
	end

	initial
	begin
		setIdle();
		lineFlip = 1'b0;
		hBlank = 1'b1;
		@(negedge nS1H1);
		// Clear both banks under blank
		lineFlip = 1'b1;
		for (int i = 0; i < sweepLen; i++)
		begin
			pixelX = 8'(i);
			nextCycle();
		end
		lineFlip = 1'b0;
		for (int i = 0; i < sweepLen; i++)
		begin
			pixelX = 8'(i);
			nextCycle();
		end
		// Random sprites into bank A
		hBlank = 1'b0;
		lineFlip = 1'b1;
		for (int i = 0; i < spriteCount; i++)
		begin
			pixelX = 8'(i);
			spriteWr.we = 1'b1;
			spriteWr.x = 8'(takeBits(8));
			spriteWr.entry.pal = 8'(takeBits(8));
			spriteWr.entry.color = 4'(takeBits(4));
			nextCycle();
		end
		spriteWr.we = 1'b0;
		lineFlip = 1'b0;	// Scan A
		for (int i = 0; i < sweepLen; i++)
		begin
			pixelX = 8'(i);
			nextCycle();
		end
		// Second scan reads zeros, B gets sprites for the fix phase
		for (int i = 0; i < sweepLen; i++)
		begin
			pixelX = 8'(i);
			spriteWr.we = (i < fixLen);
			spriteWr.x = 8'(i);
			spriteWr.entry = 12'(takeBits(12));
			nextCycle();
		end
		// Fix bytes over the sprites of bank B
		lineFlip = 1'b1;
		for (int i = 0; i < fixLen; i++)
		begin
			pixelX = 8'(i);
			spriteWr.we = 1'b1;	// Refill A for the priority phase
			spriteWr.x = 8'(i);
			spriteWr.entry = 12'(takeBits(12));
			fixIn.load = ((i % 2) == 0);	// Odd pixels use the held byte
			fixIn.data = 8'(takeBits(8));
			fixIn.pal = 4'(takeBits(4));
			if ((i % 8) == 2)
				fixIn.data[7:4] = 4'h0;	// Transparent high nibble
			if ((i % 8) == 4)
				fixIn.data[3:0] = 4'h0;
			nextCycle();
		end
		spriteWr.we = 1'b0;
		// Mixed blank, CPU and fix over bank A
		lineFlip = 1'b0;
		for (int i = 0; i < fixLen; i++)
		begin
			pixelX = 8'(i);
			hBlank = 1'(takeBits(1));
			fixIn.load = 1'(takeBits(1));
			fixIn.data = 8'(takeBits(8));
			fixIn.pal = 4'(takeBits(4));
			cpuBus.strobe = (takeBits(2) == 32'd0);
			cpuBus.write = 1'(takeBits(1));
			cpuBus.addr = 23'(takeBits(23));
			if ((i % 16) == 5)
			begin
				hBlank = 1'b1;	// CPU during blank
				cpuBus.strobe = 1'b1;
				cpuBus.addr[23] = 1'b0;
				cpuBus.addr[22] = 1'b1;
			end
			nextCycle();
		end
		setIdle();
		// Kicked frames
		for (int f = 0; f < kickFrames; f++)
		begin
			for (int c = 0; c < frameLen; c++)
			begin
				checkResetLow();
				frameStart = (c == 0);
				if (c == frameLen / 2)
					cpuBus = '{1'b1, 1'b1, b1Pkg::wdKickAddr};	// Last act of the frame
				else
					cpuBus = '0;
				nextCycle();
			end
		end
		// Frames without kicks
		cpuBus = '0;
		for (int f = 0; f < wdFrames; f++)
		begin
			checkResetLow();
			frameStart = 1'b1;
			nextCycle();
			frameStart = 1'b0;
			if (f < wdFrames - 1)
				repeat (frameLen - 1)
				begin
					checkResetLow();
					nextCycle();
				end
		end
		assert (systemReset === 1'b1)
		else
		begin
			valueErrors++;
			$display("Fail at %0t: systemReset did not rise after frame %0d", $time, wdFrames);
		end
		holdCycles = 0;
		while (systemReset === 1'b1 && holdCycles <= wdHold + 4)
		begin
			holdCycles++;
			nextCycle();
		end
		assert (holdCycles == wdHold)
		else
		begin
			valueErrors++;
			$display("Fail at %0t: systemReset held %0d cycles, expected %0d", $time,
				holdCycles, wdHold);
		end
		repeat (3) nextCycle();	// Drain the output pipeline
		finishRun();
	end

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int period = 10,	// ns
	parameter int resetCycles = 2
) (
	output logic S1H1,
	output logic nS1H1
);

	initial
	begin
		S1H1 = 1'b0;
		nS1H1 = 1'b1;	// Reset from time zero
		repeat (resetCycles) @(posedge S1H1);
		@(negedge S1H1);
		nS1H1 = 1'b0;	// Release away from the rising edge
	end

	always #(period / 2.0) S1H1 = ~S1H1;

endmodule

//--- neoB1Assertions.sv
`timescale 1ns/1ps

module neoB1Assertions #(
	parameter int wdHold = 16
) (
	input logic S1H1,
	input logic nS1H1,
	input b1Pkg::cpuBusT cpuBus,
	input b1Pkg::paSrcE paSrc,
	input logic systemReset
);

	int assertFails = 0;	// Read by the testbench at the end
	logic cpuPal;

	// Palette space strobe, bit 23 low and bit 22 high
	assign cpuPal = cpuBus.strobe && !cpuBus.addr[23] && cpuBus.addr[22];

	// Watchdog idle once reset is released
	resetLow: assert property (@(posedge S1H1) $fell(nS1H1) |-> !systemReset)
	else
	begin
		assertFails++;
		$error("systemReset is high right after reset release");
	end

	// CPU access owns the palette bus two cycles later
	cpuWins: assert property (@(posedge S1H1) disable iff (nS1H1)
		cpuPal |-> ##2 (paSrc == b1Pkg::srcCpu))
	else
	begin
		assertFails++;
		$error("paSrc is not srcCpu two cycles after a palette strobe");
	end

	// Reset pulse length
	holdLen: assert property (@(posedge S1H1) disable iff (nS1H1)
		$rose(systemReset) |-> systemReset [*wdHold] ##1 !systemReset)
	else
	begin
		assertFails++;
		$error("systemReset pulse length differs from wdHold");
	end

endmodule

bind neoB1 neoB1Assertions #(.wdHold(wdHold)) uAssert (
	.S1H1(S1H1),
	.nS1H1(nS1H1),
	.cpuBus(cpuBus),
	.paSrc(paSrc),
	.systemReset(systemReset)
);

//--- neoB1.sv
`timescale 1ns/1ps

module neoB1 #(
	parameter int wdFrames = 8,	// Frames without kick before reset
	parameter int wdHold = 16	// Reset pulse length in cycles
) (
	input logic S1H1,
	input logic nS1H1,
	input b1Pkg::cpuBusT cpuBus,
	input b1Pkg::spriteWrT spriteWr,
	input b1Pkg::fixInT fixIn,
	input logic [7:0] pixelX,
	input logic lineFlip,	// Selects render and scan banks
	input logic hBlank,
	input logic frameStart,
	output b1Pkg::palAddrT palAddr,
	output b1Pkg::paSrcE paSrc,
	output logic systemReset
);

	b1Pkg::lbEntryT sprPix;	// Scanned sprite entry, one cycle behind pixelX
	b1Pkg::fixPixT fixPix;	// Fix pixel, same alignment

	// Double-buffered sprite line
	spriteLineStage uSprite (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.spriteWr(spriteWr),
		.pixelX(pixelX),
		.lineFlip(lineFlip),
		.sprPix(sprPix)
	);

	// Fix layer latch and nibble select
	fixLatchStage uFix (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.fixIn(fixIn),
		.pixelX(pixelX),
		.fixPix(fixPix)
	);

	// Priority mux onto the palette bus
	palAddrStage uPalAddr (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.cpuBus(cpuBus),
		.hBlank(hBlank),
		.sprPix(sprPix),
		.fixPix(fixPix),
		.palAddr(palAddr),
		.paSrc(paSrc)
	);

	// Frame watchdog
	watchdog #(
		.wdFrames(wdFrames),
		.wdHold(wdHold)
	) uWatchdog (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.cpuBus(cpuBus),
		.frameStart(frameStart),
		.systemReset(systemReset)
	);

endmodule

//--- watchdog.sv
`timescale 1ns/1ps

module watchdog #(
	parameter int wdFrames = 8,
	parameter int wdHold = 16
) (
	input logic S1H1,
	input logic nS1H1,
	input b1Pkg::cpuBusT cpuBus,
	input logic frameStart,
	output logic systemReset
);

	localparam int fcW = $clog2(wdFrames + 1);	// Frame counter width
	localparam int hcW = $clog2(wdHold + 1);

	b1Pkg::wdStateE state;
	logic [fcW-1:0] frameCount;	// Frames since last kick
	logic [hcW-1:0] holdCount;	// Cycles spent in reset
	logic kick;

	assign kick = cpuBus.strobe && cpuBus.write && (cpuBus.addr == b1Pkg::wdKickAddr);

	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			state <= b1Pkg::wdRun;
			frameCount <= '0;
			holdCount <= '0;
		end
		else
		begin
			case (state)
				b1Pkg::wdRun:
				begin
					holdCount <= '0;
					if (kick)
						frameCount <= '0;	// Kick wins over a frame in the same cycle
					else if (frameStart)
					begin
						if (frameCount == fcW'(wdFrames - 1))
						begin
							state <= b1Pkg::wdFire;	// Expired
							frameCount <= '0;
						end
						else
							frameCount <= frameCount + 1'b1;
					end
				end
				b1Pkg::wdFire:
				begin
					frameCount <= '0;	// Frames and kicks ignored while firing
					if (holdCount == hcW'(wdHold - 1))
						state <= b1Pkg::wdRun;
					else
						holdCount <= holdCount + 1'b1;
				end
				default: state <= b1Pkg::wdRun;
			endcase
		end
	end

	assign systemReset = (state == b1Pkg::wdFire);	// High for wdHold cycles

endmodule

//--- palAddrStage.sv
`timescale 1ns/1ps

module palAddrStage (
	input logic S1H1,
	input logic nS1H1,
	input b1Pkg::cpuBusT cpuBus,
	input logic hBlank,
	input b1Pkg::lbEntryT sprPix,
	input b1Pkg::fixPixT fixPix,
	output b1Pkg::palAddrT palAddr,
	output b1Pkg::paSrcE paSrc
);

	logic cpuPal;	// Palette space $400000 to $7FFFFF
	logic cpuPalD;
	logic [11:0] cpuAddrD;	// CPU word address bits 12 to 1
	logic hBlankD;
	b1Pkg::palAddrT nextAddr;
	b1Pkg::paSrcE nextSrc;

	assign cpuPal = cpuBus.strobe && !cpuBus.addr[23] && cpuBus.addr[22];

	// Align with the stage registers
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			cpuPalD <= 1'b0;
			cpuAddrD <= '0;
			hBlankD <= 1'b0;
		end
		else
		begin
			cpuPalD <= cpuPal;
			cpuAddrD <= cpuBus.addr[12:1];
			hBlankD <= hBlank;
		end
	end

	// CPU, then blank, then opaque fix, then sprite
	always_comb
	begin
		if (cpuPalD)
		begin
			nextAddr = cpuAddrD;
			nextSrc = b1Pkg::srcCpu;
		end
		else if (hBlankD)
		begin
			nextAddr = '0;
			nextSrc = b1Pkg::srcBlank;
		end
		else if (fixPix.pix != 4'd0)
		begin
			nextAddr = {4'd0, fixPix.pal, fixPix.pix};	// Fix palettes sit in the low 256
			nextSrc = b1Pkg::srcFix;
		end
		else
		begin
			nextAddr = {sprPix.pal, sprPix.color};
			nextSrc = b1Pkg::srcSprite;
		end
	end

	// Output register
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			palAddr <= '0;
			paSrc <= b1Pkg::srcBlank;
		end
		else
		begin
			palAddr <= nextAddr;
			paSrc <= nextSrc;
		end
	end

endmodule

//--- fixLatchStage.sv
`timescale 1ns/1ps

module fixLatchStage (
	input logic S1H1,
	input logic nS1H1,
	input b1Pkg::fixInT fixIn,
	input logic [7:0] pixelX,
	output b1Pkg::fixPixT fixPix
);

	logic [7:0] heldData;	// Last loaded tile byte
	logic [3:0] heldPal;
	logic [7:0] curData;
	logic [3:0] curPal;

	// New byte takes effect in its load cycle
	assign curData = fixIn.load ? fixIn.data : heldData;
	assign curPal = fixIn.load ? fixIn.pal : heldPal;

	// Tile latch
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			heldData <= '0;
			heldPal <= '0;
		end
		else if (fixIn.load)
		begin
			heldData <= fixIn.data;
			heldPal <= fixIn.pal;
		end
	end

	// Pixel parity picks the nibble
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
			fixPix <= '0;	// Transparent
		else
		begin
			fixPix.pal <= curPal;
			fixPix.pix <= pixelX[0] ? curData[7:4] : curData[3:0];	// Odd is high
		end
	end

endmodule

//--- spriteLineStage.sv
`timescale 1ns/1ps

module spriteLineStage (
	input logic S1H1,
	input logic nS1H1,
	input b1Pkg::spriteWrT spriteWr,
	input logic [7:0] pixelX,
	input logic lineFlip,
	output b1Pkg::lbEntryT sprPix
);

	// Bank A write port
	logic wrEnA;
	logic [7:0] wrAddrA;
	b1Pkg::lbEntryT wrDataA;
	b1Pkg::lbEntryT rdDataA;

	// Bank B write port
	logic wrEnB;
	logic [7:0] wrAddrB;
	b1Pkg::lbEntryT wrDataB;
	b1Pkg::lbEntryT rdDataB;

	logic scanB;	// Bank B was scanned last cycle

	// Flip high renders into A and scans B
	assign wrEnA = lineFlip ? spriteWr.we : 1'b1;	// Scanned bank always clears
	assign wrAddrA = lineFlip ? spriteWr.x : pixelX;
	assign wrDataA = lineFlip ? spriteWr.entry : '0;	// Zero entry is transparent

	// Flip low renders into B and scans A
	assign wrEnB = lineFlip ? 1'b1 : spriteWr.we;
	assign wrAddrB = lineFlip ? pixelX : spriteWr.x;
	assign wrDataB = lineFlip ? '0 : spriteWr.entry;

	lineBuffer #(
		.depth(b1Pkg::lbDepth)
	) bankA (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.wrEn(wrEnA),
		.wrAddr(wrAddrA),
		.wrData(wrDataA),
		.rdAddr(pixelX),	// Render side read is ignored
		.rdData(rdDataA)
	);

	lineBuffer #(
		.depth(b1Pkg::lbDepth)
	) bankB (
		.S1H1(S1H1),
		.nS1H1(nS1H1),
		.wrEn(wrEnB),
		.wrAddr(wrAddrB),
		.wrData(wrDataB),
		.rdAddr(pixelX),
		.rdData(rdDataB)
	);

	// Select follows the read latency
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
			scanB <= 1'b0;
		else
			scanB <= lineFlip;
	end

	assign sprPix = scanB ? rdDataB : rdDataA;	// Scanned bank out

endmodule

//--- lineBuffer.sv
`timescale 1ns/1ps

module lineBuffer #(
	parameter int depth = b1Pkg::lbDepth
) (
	input logic S1H1,
	input logic nS1H1,
	input logic wrEn,
	input logic [7:0] wrAddr,
	input b1Pkg::lbEntryT wrData,
	input logic [7:0] rdAddr,
	output b1Pkg::lbEntryT rdData
);

	b1Pkg::lbEntryT mem [depth];	// One bank of pixels

	// Write port
	always_ff @(posedge S1H1)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// Registered read, sees the old entry on a same-address write
	always_ff @(posedge S1H1 or posedge nS1H1)
	begin
		if (nS1H1)
			rdData <= '0;
		else
			rdData <= mem[rdAddr];
	end

endmodule

//--- b1Pkg.sv
package b1Pkg;

	// Line buffer geometry
	localparam int lbDepth = 256;	// Entries per bank, one per pixel on the line

	// Watchdog kick register, word address of $300001
	localparam logic [23:1] wdKickAddr = 23'h18_0000;

	typedef logic [11:0] palAddrT;	// Palette RAM address

	// One line buffer entry
	typedef struct packed {
		logic [7:0] pal;	// Sprite palette
		logic [3:0] color;	// Zero is transparent
	} lbEntryT;

	// Sprite pixel write into the render bank
	typedef struct packed {
		logic we;
		logic [7:0] x;
		lbEntryT entry;
	} spriteWrT;

	// Fix tile byte, two 4-bit pixels plus palette
	typedef struct packed {
		logic load;
		logic [7:0] data;	// High nibble for odd pixels
		logic [3:0] pal;
	} fixInT;

	// One fix pixel
	typedef struct packed {
		logic [3:0] pal;
		logic [3:0] pix;	// Opaque when nonzero
	} fixPixT;

	// CPU bus snapshot for one cycle
	typedef struct packed {
		logic strobe;
		logic write;
		logic [23:1] addr;
	} cpuBusT;

	typedef enum logic [1:0] {srcCpu, srcBlank, srcFix, srcSprite} paSrcE;	// PA source tag
	typedef enum logic {wdRun, wdFire} wdStateE;

endpackage
